/* sim.f */
src/extract_isa_pkg.sv
src/extract_pipe_pkg.sv
src/line_aligner.sv
src/branch_decode.sv
src/flow_select.sv
src/group_stage.sv
src/extract_top.sv
sim/extract_props.sv
sim/extract_checker.sv
sim/tb_top.sv

/* Bender.yml */
package:
  name: extract_stage

sources:
  # Packages first, then the stage from the leaves up
  - src/extract_isa_pkg.sv
  - src/extract_pipe_pkg.sv
  - src/line_aligner.sv
  - src/branch_decode.sv
  - src/flow_select.sv
  - src/group_stage.sv
  - src/extract_top.sv

  - target: test
    files:
      - sim/extract_props.sv
      - sim/extract_checker.sv
      - sim/tb_top.sv

/* sim/tb_top.sv */
`default_nettype none

module tb_top;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int RESET_CYCLES = 16;
	localparam int DRAIN_LIMIT = 20;
	localparam int RUN_LIMIT_NS = 200_000;

	logic clk = 1'b0;
	logic rst_i;
	logic en_i;
	logic [extract_isa_pkg::LINE_W-1:0] line_i;
	extract_isa_pkg::pc_t pc_i;
	logic [extract_pipe_pkg::SLOTS-1:0] pred_taken_i;
	logic stomp_i;
	logic irq_i;
	logic ssm_i;
	logic flush_i;
	logic branchmiss_i;
	extract_isa_pkg::pc_t misspc_i;
	extract_pipe_pkg::group_t group_o;
	extract_pipe_pkg::redirect_t redirect_o;
	extract_isa_pkg::pc_t ret_pc_o;

	// From the checker
	int err_count_o;
	logic pending_o;

	integer seed;
	int timeouts;

	// 40 ns period
	always #20 clk = ~clk;

	extract_top u_dut (.*);

	extract_checker u_chk (.*);

	bind extract_top extract_props u_props (.*);

	// ============================================================
	// Stimulus helpers
	// ============================================================
	// Inputs change 2 ns after the rising edge
	task automatic tick();
		@(posedge clk);
		#2;
	endtask

	task automatic rand_line();
		for (int w = 0; w < extract_isa_pkg::LINE_W / 32; w++) begin
			line_i[32*w +: 32] = $random(seed);
		end
	endtask

	function automatic extract_isa_pkg::opcode_e pick_opcode();
		case ($unsigned($random(seed)) % 7)
			0: return extract_isa_pkg::OP_NOP;
			1: return extract_isa_pkg::OP_ALU;
			2: return extract_isa_pkg::OP_BSR;
			3: return extract_isa_pkg::OP_BRA;
			4: return extract_isa_pkg::OP_BCC;
			5: return extract_isa_pkg::OP_JSR;
			default: return extract_isa_pkg::OP_JMP;
		endcase
	endfunction

	// Write one instruction where slot s of the current PC lands in the line
	task automatic put_insn(input int s, input extract_isa_pkg::opcode_e op, input logic [31:0] fld);
		extract_isa_pkg::insn_t insn;
		int ofs;
		insn = '0;
		insn.opcode = op;
		insn.field = fld;
		ofs = int'(pc_i[extract_isa_pkg::OFS_MSB:extract_isa_pkg::OFS_LSB]) * 2 + s * 6;
		for (int j = 0; j < 6; j++) begin
			// Bytes past the line end are dropped, the DUT pads there
			if (ofs + j < 64) begin
				line_i[8*(ofs+j) +: 8] = insn[8*j +: 8];
			end
		end
	endtask

	task automatic rand_group();
		rand_line();
		pc_i = $random(seed);
		pc_i[0] = 1'b0;
		pred_taken_i = 4'($random(seed));
		for (int s = 0; s < extract_pipe_pkg::SLOTS; s++) begin
			put_insn(s, pick_opcode(), $random(seed));
		end
	endtask

	task automatic quiet();
		en_i = 1'b1;
		stomp_i = 1'b0;
		irq_i = 1'b0;
		ssm_i = 1'b0;
		flush_i = 1'b0;
		branchmiss_i = 1'b0;
	endtask

	// Stall and let the checker catch up with the last group
	task automatic drain();
		int n;
		en_i = 1'b0;
		n = 0;
		while (pending_o && n < DRAIN_LIMIT) begin
			@(posedge clk);
			n++;
		end
		#2;
		if (pending_o) begin
			$display("timeout: last group not checked within %0d cycles", DRAIN_LIMIT);
			timeouts++;
		end
	endtask

	// ============================================================
	// Test sequence
	// ============================================================
	initial begin
		int span;
		seed = 8725;
		timeouts = 0;
		rst_i = 1'b1;
		en_i = 1'b0;
		line_i = '0;
		pc_i = extract_isa_pkg::RST_PC;
		pred_taken_i = '0;
		stomp_i = 1'b0;
		irq_i = 1'b0;
		ssm_i = 1'b0;
		flush_i = 1'b0;
		branchmiss_i = 1'b0;
		misspc_i = '0;
		for (int n = 0; n < RESET_CYCLES; n++) begin
			tick();
		end
		u_chk.start_test("reset");
		rst_i = 1'b0;
		tick();
		u_chk.finish_test();

		// Random bytes at random parcel offsets
		u_chk.start_test("alignment");
		quiet();
		for (int n = 0; n < 24; n++) begin
			rand_line();
			pc_i = $random(seed);
			pc_i[0] = 1'b0;
			tick();
		end
		drain();
		u_chk.finish_test();

		u_chk.start_test("redirect");
		quiet();
		for (int n = 0; n < 40; n++) begin
			rand_group();
			tick();
		end
		// Not-taken BCC in slot 0 is skipped, JSR in slot 2 wins
		rand_line();
		pc_i = 32'h0000_2000;
		pred_taken_i = 4'b0000;
		put_insn(0, extract_isa_pkg::OP_BCC, 32'h40);
		put_insn(1, extract_isa_pkg::OP_ALU, 32'h0);
		put_insn(2, extract_isa_pkg::OP_JSR, 32'h0000_8000);
		tick();
		// BRA to the next sequential group, so no override
		put_insn(0, extract_isa_pkg::OP_BRA, 32'd24);
		tick();
		drain();
		u_chk.finish_test();

		u_chk.start_test("stomp_causes");
		quiet();
		for (int n = 0; n < 20; n++) begin
			rand_group();
			branchmiss_i = ($random(seed) & 1) != 0;
			misspc_i = pc_i + extract_isa_pkg::pc_t'($unsigned($random(seed)) % 28);
			stomp_i = ($random(seed) & 7) == 0;
			irq_i = ($random(seed) & 7) == 0;
			tick();
		end
		quiet();
		// Same PC and line twice in a row
		rand_group();
		tick();
		tick();
		drain();
		u_chk.finish_test();

		u_chk.start_test("single_step");
		quiet();
		rand_group();
		tick();
		ssm_i = 1'b1;
		for (int n = 0; n < 4; n++) begin
			rand_group();
			put_insn(0, extract_isa_pkg::OP_ALU, 32'h0);
			tick();
		end
		drain();
		u_chk.finish_test();

		// Enable low for random spans of one to four cycles
		u_chk.start_test("stall");
		quiet();
		span = 0;
		for (int n = 0; n < 48; n++) begin
			if (span == 0) begin
				en_i = ($random(seed) & 1) != 0;
				span = 1 + $unsigned($random(seed)) % 4;
			end
			span--;
			flush_i = ($random(seed) & 1) != 0;
			rand_group();
			tick();
		end
		quiet();
		drain();
		u_chk.finish_test();

		u_chk.report();
		if (err_count_o == 0 && timeouts == 0 && u_dut.u_props.fail_cnt == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	// Guard against a run that never reaches the end
	initial begin
		#(RUN_LIMIT_NS);
		$display("timeout: simulation did not finish within %0d ns", RUN_LIMIT_NS);
		$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/extract_checker.sv */
`default_nettype none

module extract_checker (
	input  logic                               clk,
	input  logic                               rst_i,
	input  logic                               en_i,
	input  logic [extract_isa_pkg::LINE_W-1:0] line_i,
	input  extract_isa_pkg::pc_t               pc_i,
	input  logic [extract_pipe_pkg::SLOTS-1:0] pred_taken_i,
	input  logic                               stomp_i,
	input  logic                               irq_i,
	input  logic                               ssm_i,
	input  logic                               flush_i,
	input  logic                               branchmiss_i,
	input  extract_isa_pkg::pc_t               misspc_i,
	input  extract_pipe_pkg::group_t           group_o,
	input  extract_pipe_pkg::redirect_t        redirect_o,
	input  extract_isa_pkg::pc_t               ret_pc_o,
	output int                                 err_count_o,
	output logic                               pending_o
);
	timeunit 1ns;
	timeprecision 1ps;

	typedef extract_isa_pkg::insn_t [extract_pipe_pkg::SLOTS-1:0] win_t;

	// Group expected on group_o after the last enabled edge
	extract_pipe_pkg::group_t exp_group;
	logic exp_reset;
	logic have_exp;

	// Model state, last enabled edge
	extract_isa_pkg::pc_t last_pc;
	win_t last_win;
	logic last_vld;
	logic last_ssm;

	string test_name;
	int test_errs;
	int tests_run;
	int tests_failed;

	initial begin
		err_count_o = 0;
		pending_o = 1'b0;
		have_exp = 1'b0;
		exp_reset = 1'b0;
		last_vld = 1'b0;
		last_ssm = 1'b0;
		test_name = "reset";
		test_errs = 0;
		tests_run = 0;
		tests_failed = 0;
	end

	// ============================================================
	// Reference model
	// ============================================================
	// Six bytes at PC plus 6*slot within the line
	function automatic extract_isa_pkg::insn_t cut_insn(
		input logic [extract_isa_pkg::LINE_W-1:0] line,
		input extract_isa_pkg::pc_t pc,
		input int slot
	);
		logic [extract_isa_pkg::INSN_W-1:0] raw;
		int base;
		base = int'(pc[extract_isa_pkg::OFS_MSB:extract_isa_pkg::OFS_LSB]) * 2 + slot * 6;
		for (int j = 0; j < 6; j++) begin
			if (base + j < 64) begin
				raw[8*j +: 8] = line[8*(base+j) +: 8];
			end else begin
				// Filler NOPs are stacked from the line end upward
				raw[8*j +: 8] = extract_isa_pkg::NOP_INSN[8*((base + j - 64) % 6) +: 8];
			end
		end
		return raw;
	endfunction

	function automatic extract_isa_pkg::pc_t flow_target(
		input extract_isa_pkg::insn_t insn,
		input extract_isa_pkg::pc_t slot_pc
	);
		// Jumps carry the address, branches a displacement from the slot
		if (insn.opcode == extract_isa_pkg::OP_JSR ||
			insn.opcode == extract_isa_pkg::OP_JMP) begin
			return insn.field;
		end
		return slot_pc + insn.field;
	endfunction

	function automatic extract_pipe_pkg::redirect_t ref_redirect(
		input win_t win,
		input extract_isa_pkg::pc_t pc,
		input logic [extract_pipe_pkg::SLOTS-1:0] pred
	);
		extract_pipe_pkg::redirect_t rd;
		logic [6:0] op;
		logic hit;
		logic found;
		rd = '0;
		rd.target = extract_isa_pkg::RST_PC;
		found = 1'b0;
		// Walk down so the lowest redirecting slot is written last
		for (int i = extract_pipe_pkg::SLOTS - 1; i >= 0; i--) begin
			op = win[i].opcode;
			hit = (op == extract_isa_pkg::OP_BSR) || (op == extract_isa_pkg::OP_BRA) ||
				(op == extract_isa_pkg::OP_JSR) || (op == extract_isa_pkg::OP_JMP) ||
				(op == extract_isa_pkg::OP_BCC && pred[i]);
			if (hit) begin
				found = 1'b1;
				rd.pos = extract_pipe_pkg::pos_t'(i);
				rd.target = flow_target(win[i], pc + 6 * i);
				rd.is_call = (op == extract_isa_pkg::OP_BSR) || (op == extract_isa_pkg::OP_JSR);
			end
		end
		// Target equal to the next group is what fetch does anyway
		rd.override = found && (rd.target != pc + 24);
		return rd;
	endfunction

	function automatic extract_pipe_pkg::group_t ref_group(
		input win_t win,
		input extract_isa_pkg::pc_t pc,
		input logic [extract_pipe_pkg::SLOTS-1:0] pred,
		input logic kill_all,
		input logic ssm,
		input logic ssm_first,
		input logic flush,
		input logic miss,
		input extract_isa_pkg::pc_t miss_pc,
		input extract_pipe_pkg::redirect_t rd
	);
		extract_pipe_pkg::group_t g;
		extract_isa_pkg::pc_t spc;
		logic [6:0] op;
		logic kill;
		g.hdr.pc = pc;
		g.hdr.flush = flush;
		g.hdr.ssm = ssm;
		for (int i = 0; i < extract_pipe_pkg::SLOTS; i++) begin
			spc = pc + 6 * i;
			op = win[i].opcode;
			kill = kill_all || (miss && miss_pc > spc) || (rd.override && i > rd.pos);
			// Single step passes slot 0 of the first cycle only
			if (ssm && !(ssm_first && i == 0)) begin
				kill = 1'b1;
			end
			if (op == extract_isa_pkg::OP_NOP || op == extract_isa_pkg::OP_BRA ||
				op == extract_isa_pkg::OP_JMP) begin
				kill = 1'b1;
			end
			g.slot[i].insn = win[i];
			g.slot[i].pc = spc;
			g.slot[i].pred_taken = pred[i];
			g.slot[i].valid = !kill;
			g.slot[i].done = kill;
			g.slot[i].stomped = kill;
		end
		return g;
	endfunction

	// ============================================================
	// Reporting
	// ============================================================
	task automatic report_value(input string what, input logic [127:0] exp_v,
		input logic [127:0] got_v);
		test_errs++;
		err_count_o++;
		$display("FAIL %s %s: expected %h actual %h", test_name, what, exp_v, got_v);
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errs = 0;
	endtask

	task automatic finish_test();
		tests_run++;
		if (test_errs == 0) begin
			$display("test %s: ok", test_name);
		end else begin
			tests_failed++;
			$display("test %s: %0d mismatches", test_name, test_errs);
		end
	endtask

	task automatic report();
		$display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed,
			err_count_o);
	endtask

	// ============================================================
	// Compare, mid cycle where inputs and outputs are settled
	// ============================================================
	always @(negedge clk) begin : b_compare
		win_t win;
		extract_pipe_pkg::redirect_t exp_rd;
		extract_isa_pkg::pc_t exp_ret;
		logic redundant;
		for (int i = 0; i < extract_pipe_pkg::SLOTS; i++) begin
			win[i] = cut_insn(line_i, pc_i, i);
		end
		exp_rd = ref_redirect(win, pc_i, pred_taken_i);
		exp_ret = exp_rd.is_call ?
			pc_i + extract_isa_pkg::pc_t'(6 * (int'(exp_rd.pos) + 1)) : extract_isa_pkg::RST_PC;

		// Redirect follows the present inputs, stalled or not
		if (!rst_i) begin
			if (redirect_o !== exp_rd) begin
				report_value("redirect", exp_rd, redirect_o);
			end
			if (ret_pc_o !== exp_ret) begin
				report_value("return pc", exp_ret, ret_pc_o);
			end
		end

		if (have_exp) begin
			if (group_o.hdr !== exp_group.hdr) begin
				report_value("header", exp_group.hdr, group_o.hdr);
			end
			for (int i = 0; i < extract_pipe_pkg::SLOTS; i++) begin
				// Reset defines only the status bits of a slot
				if (exp_reset) begin
					if ({group_o.slot[i].valid, group_o.slot[i].done,
						group_o.slot[i].stomped} !== 3'b011) begin
						report_value($sformatf("slot %0d status", i), 3'b011,
							{group_o.slot[i].valid, group_o.slot[i].done,
							group_o.slot[i].stomped});
					end
				end else if (group_o.slot[i] !== exp_group.slot[i]) begin
					report_value($sformatf("slot %0d", i), exp_group.slot[i], group_o.slot[i]);
				end
			end
		end
		pending_o = 1'b0;

		// Predict what the coming edge will register
		if (rst_i) begin
			have_exp = 1'b1;
			exp_reset = 1'b1;
			exp_group.hdr.pc = extract_isa_pkg::RST_PC;
			exp_group.hdr.flush = 1'b0;
			exp_group.hdr.ssm = 1'b0;
			last_vld = 1'b0;
			last_ssm = 1'b0;
		end else if (en_i) begin
			redundant = last_vld && (last_pc == pc_i) && (last_win == win);
			exp_group = ref_group(win, pc_i, pred_taken_i, stomp_i || irq_i || redundant,
				ssm_i, ssm_i && !last_ssm, flush_i, branchmiss_i, misspc_i, exp_rd);
			exp_reset = 1'b0;
			last_pc = pc_i;
			last_win = win;
			last_vld = 1'b1;
			last_ssm = ssm_i;
			pending_o = 1'b1;
		end
	end

endmodule

`default_nettype wire

/* sim/extract_props.sv */
`default_nettype none

module extract_props (
	input logic                     clk,
	input logic                     rst_i,
	input logic                     en_i,
	input logic                     stomp_i,
	input logic                     irq_i,
	input extract_pipe_pkg::group_t group_o
);
	timeunit 1ns;
	timeprecision 1ps;

	// Count of property failures
	int fail_cnt = 0;

	for (genvar i = 0; i < extract_pipe_pkg::SLOTS; i++) begin : g_slot
		// Reset leaves decode with an empty group
		a_reset_empty: assert property (@(posedge clk) rst_i |=> !group_o.slot[i].valid)
			else begin
				fail_cnt++;
				$error("slot %0d valid right after reset", i);
			end

		// External stomp or interrupt kills the whole next group
		a_kill_all: assert property (@(posedge clk) disable iff (rst_i)
			en_i && (stomp_i || irq_i) |=> group_o.slot[i].stomped)
			else begin
				fail_cnt++;
				$error("slot %0d not stomped after stomp or interrupt", i);
			end

		// NOP, BRA and JMP slots leave as stomped and done
		a_stomp_done: assert property (@(posedge clk) disable iff (rst_i)
			group_o.slot[i].insn.opcode inside {extract_isa_pkg::OP_NOP,
				extract_isa_pkg::OP_BRA, extract_isa_pkg::OP_JMP}
			|-> group_o.slot[i].stomped && group_o.slot[i].done)
			else begin
				fail_cnt++;
				$error("slot %0d holds a NOP or jump but is not stomped and done", i);
			end
	end

endmodule

`default_nettype wire

/* src/extract_top.sv */
`default_nettype none

module extract_top (
	input  logic                                       clk,
	input  logic                                       rst_i,
	input  logic                                       en_i,
	input  logic [extract_isa_pkg::LINE_W-1:0]         line_i,
	input  extract_isa_pkg::pc_t                       pc_i,
	input  logic [extract_pipe_pkg::SLOTS-1:0]         pred_taken_i,
	input  logic                                       stomp_i,
	input  logic                                       irq_i,
	input  logic                                       ssm_i,
	input  logic                                       flush_i,
	input  logic                                       branchmiss_i,
	input  extract_isa_pkg::pc_t                       misspc_i,
	output extract_pipe_pkg::group_t                   group_o,
	output extract_pipe_pkg::redirect_t                redirect_o,
	output extract_isa_pkg::pc_t                       ret_pc_o
);

	extract_isa_pkg::pc_t    [extract_pipe_pkg::SLOTS-1:0] slot_pc;
	extract_isa_pkg::insn_t  [extract_pipe_pkg::SLOTS-1:0] slot_insn;
	extract_pipe_pkg::flow_e [extract_pipe_pkg::SLOTS-1:0] flow;
	extract_isa_pkg::pc_t    [extract_pipe_pkg::SLOTS-1:0] target;
	logic redundant;

	// ============================================================
	// Align and cut the group
	// ============================================================
	line_aligner u_aligner (
		.clk         (clk),
		.rst_i       (rst_i),
		.en_i        (en_i),
		.line_i      (line_i),
		.pc_i        (pc_i),
		.slot_pc_o   (slot_pc),
		.slot_insn_o (slot_insn),
		.redundant_o (redundant)
	);

	// One pre-decoder per slot
	for (genvar g = 0; g < extract_pipe_pkg::SLOTS; g++) begin : g_dec
		branch_decode u_dec (
			.slot_pc_i    (slot_pc[g]),
			.insn_i       (slot_insn[g]),
			.pred_taken_i (pred_taken_i[g]),
			.flow_o       (flow[g]),
			.target_o     (target[g])
		);
	end

	// Redirect goes out the same cycle
	flow_select u_select (
		.flow_i     (flow),
		.target_i   (target),
		.slot_pc_i  (slot_pc),
		.pc_i       (pc_i),
		.redirect_o (redirect_o),
		.ret_pc_o   (ret_pc_o)
	);

	// ============================================================
	// Stomp and register for decode
	// ============================================================
	group_stage u_group (
		.clk          (clk),
		.rst_i        (rst_i),
		.en_i         (en_i),
		.pc_i         (pc_i),
		.slot_pc_i    (slot_pc),
		.slot_insn_i  (slot_insn),
		.flow_i       (flow),
		.pred_taken_i (pred_taken_i),
		.redundant_i  (redundant),
		.redirect_i   (redirect_o),
		.stomp_i      (stomp_i),
		.irq_i        (irq_i),
		.ssm_i        (ssm_i),
		.flush_i      (flush_i),
		.branchmiss_i (branchmiss_i),
		.misspc_i     (misspc_i),
		.group_o      (group_o)
	);

endmodule

`default_nettype wire

/* src/group_stage.sv */
`default_nettype none

module group_stage (
	input  logic                                                  clk,
	input  logic                                                  rst_i,
	input  logic                                                  en_i,
	input  extract_isa_pkg::pc_t                                  pc_i,
	input  extract_isa_pkg::pc_t    [extract_pipe_pkg::SLOTS-1:0] slot_pc_i,
	input  extract_isa_pkg::insn_t  [extract_pipe_pkg::SLOTS-1:0] slot_insn_i,
	input  extract_pipe_pkg::flow_e [extract_pipe_pkg::SLOTS-1:0] flow_i,
	input  logic                    [extract_pipe_pkg::SLOTS-1:0] pred_taken_i,
	input  logic                                                  redundant_i,
	input  extract_pipe_pkg::redirect_t                           redirect_i,
	input  logic                                                  stomp_i,
	input  logic                                                  irq_i,
	input  logic                                                  ssm_i,
	input  logic                                                  flush_i,
	input  logic                                                  branchmiss_i,
	input  extract_isa_pkg::pc_t                                  misspc_i,
	output extract_pipe_pkg::group_t                              group_o
);

	logic prev_ssm;
	// Rising edge of single-step, lets exactly one slot through
	logic ssm_first;
	extract_pipe_pkg::stomp_cause_t [extract_pipe_pkg::SLOTS-1:0] cause;
	extract_pipe_pkg::group_t nxt;

	assign ssm_first = ssm_i && !prev_ssm;

	// ============================================================
	// Stomp rules
	// ============================================================
	always_comb begin
		nxt.hdr.pc = pc_i;
		nxt.hdr.flush = flush_i;
		nxt.hdr.ssm = ssm_i;
		for (int i = 0; i < extract_pipe_pkg::SLOTS; i++) begin
			cause[i].ext = stomp_i;
			cause[i].irq = irq_i;
			cause[i].redundant = redundant_i;
			// Slots before the miss address belong to the wrong path
			cause[i].miss = branchmiss_i && (misspc_i > slot_pc_i[i]);
			cause[i].after_ovr = redirect_i.override && (i > redirect_i.pos);
			cause[i].ssm = ssm_i && !(i == 0 && ssm_first);
			// Jumps finish here, NOPs never need to run
			cause[i].kind = (slot_insn_i[i].opcode == extract_isa_pkg::OP_NOP) ||
				(flow_i[i] == extract_pipe_pkg::FLOW_BRA) ||
				(flow_i[i] == extract_pipe_pkg::FLOW_JMP);

			nxt.slot[i].insn = slot_insn_i[i];
			nxt.slot[i].pc = slot_pc_i[i];
			nxt.slot[i].pred_taken = pred_taken_i[i];
			nxt.slot[i].stomped = |cause[i];
			nxt.slot[i].valid = ~|cause[i];
			nxt.slot[i].done = |cause[i];
		end
	end

	// ============================================================
	// Pipeline registers
	// ============================================================
	always_ff @(posedge clk) begin
		if (rst_i) begin
			prev_ssm <= 1'b0;
		end else if (en_i) begin
			prev_ssm <= ssm_i;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			group_o.hdr.pc <= extract_isa_pkg::RST_PC;
			group_o.hdr.flush <= 1'b0;
			group_o.hdr.ssm <= 1'b0;
			// Decode sees an empty group until the first real one
			for (int i = 0; i < extract_pipe_pkg::SLOTS; i++) begin
				group_o.slot[i].valid <= 1'b0;
				group_o.slot[i].stomped <= 1'b1;
				group_o.slot[i].done <= 1'b1;
			end
		end else if (en_i) begin
			group_o <= nxt;
		end
	end

endmodule

`default_nettype wire

/* src/flow_select.sv */
`default_nettype none

module flow_select (
	input  extract_pipe_pkg::flow_e [extract_pipe_pkg::SLOTS-1:0] flow_i,
	input  extract_isa_pkg::pc_t    [extract_pipe_pkg::SLOTS-1:0] target_i,
	input  extract_isa_pkg::pc_t    [extract_pipe_pkg::SLOTS-1:0] slot_pc_i,
	input  extract_isa_pkg::pc_t                                   pc_i,
	output extract_pipe_pkg::redirect_t                            redirect_o,
	output extract_isa_pkg::pc_t                                   ret_pc_o
);

	// A redirecting slot was found in this group
	logic found;
	logic call;
	// Where fetch goes anyway when nothing redirects
	extract_isa_pkg::pc_t seq_pc;

	always_comb begin
		found = 1'b0;
		call = 1'b0;
		seq_pc = pc_i + extract_isa_pkg::pc_t'(extract_pipe_pkg::GROUP_BYTES);
		redirect_o = '0;
		redirect_o.target = extract_isa_pkg::RST_PC;
		ret_pc_o = extract_isa_pkg::RST_PC;

		// ============================================================
		// Priority pick, lowest slot wins
		// ============================================================
		for (int i = 0; i < extract_pipe_pkg::SLOTS; i++) begin
			if (!found && flow_i[i] != extract_pipe_pkg::FLOW_NONE) begin
				found = 1'b1;
				redirect_o.pos = extract_pipe_pkg::pos_t'(i);
				redirect_o.target = target_i[i];
				call = (flow_i[i] == extract_pipe_pkg::FLOW_BSR) ||
					(flow_i[i] == extract_pipe_pkg::FLOW_JSR);
				// Return lands right after the call slot
				if (call) begin
					ret_pc_o = slot_pc_i[i] +
						extract_isa_pkg::pc_t'(extract_isa_pkg::INSN_BYTES);
				end
			end
		end

		redirect_o.is_call = call;
		// Predictor already fetched sequentially, only a different target overrides
		redirect_o.override = found && (redirect_o.target != seq_pc);
	end

endmodule

`default_nettype wire

/* src/branch_decode.sv */
`default_nettype none

module branch_decode (
	input  extract_isa_pkg::pc_t    slot_pc_i,
	input  extract_isa_pkg::insn_t  insn_i,
	input  logic                    pred_taken_i,
	output extract_pipe_pkg::flow_e flow_o,
	output extract_isa_pkg::pc_t    target_o
);

	// 32-bit field, displacement or absolute address
	extract_isa_pkg::pc_t disp;
	extract_isa_pkg::pc_t rel_tgt;

	always_comb begin
		disp = insn_i[extract_isa_pkg::DISP_LSB +: extract_isa_pkg::PC_W];
		// Relative to the slot itself, not the group
		rel_tgt = slot_pc_i + disp;
		flow_o = extract_pipe_pkg::FLOW_NONE;
		target_o = extract_isa_pkg::RST_PC;
		case (insn_i.opcode)
			extract_isa_pkg::OP_BSR: begin
				flow_o = extract_pipe_pkg::FLOW_BSR;
				target_o = rel_tgt;
			end
			extract_isa_pkg::OP_BRA: begin
				flow_o = extract_pipe_pkg::FLOW_BRA;
				target_o = rel_tgt;
			end
			extract_isa_pkg::OP_BCC: begin
				// Not-taken branches fall through, no redirect
				flow_o = pred_taken_i ? extract_pipe_pkg::FLOW_BCC : extract_pipe_pkg::FLOW_NONE;
				target_o = rel_tgt;
			end
			extract_isa_pkg::OP_JSR: begin
				flow_o = extract_pipe_pkg::FLOW_JSR;
				target_o = disp;
			end
			extract_isa_pkg::OP_JMP: begin
				flow_o = extract_pipe_pkg::FLOW_JMP;
				target_o = disp;
			end
			default: begin
				flow_o = extract_pipe_pkg::FLOW_NONE;
			end
		endcase
	end

endmodule

`default_nettype wire

/* src/line_aligner.sv */
`default_nettype none

module line_aligner (
	input  logic                                                  clk,
	input  logic                                                  rst_i,
	input  logic                                                  en_i,
	input  logic [extract_isa_pkg::LINE_W-1:0]                    line_i,
	input  extract_isa_pkg::pc_t                                  pc_i,
	output extract_isa_pkg::pc_t   [extract_pipe_pkg::SLOTS-1:0]  slot_pc_o,
	output extract_isa_pkg::insn_t [extract_pipe_pkg::SLOTS-1:0]  slot_insn_o,
	output logic                                                  redundant_o
);

	// Line with a group's worth of NOPs stacked above its last byte
	logic [extract_isa_pkg::LINE_W+extract_pipe_pkg::WIN_W-1:0] padded;
	logic [extract_isa_pkg::LINE_W+extract_pipe_pkg::WIN_W-1:0] shifted;
	logic [extract_pipe_pkg::WIN_W-1:0] window;
	logic [extract_isa_pkg::SHAMT_W-1:0] shamt;

	// Last group seen on an enabled edge
	extract_isa_pkg::pc_t prev_pc;
	logic [extract_pipe_pkg::WIN_W-1:0] prev_win;
	logic prev_vld;

	// ============================================================
	// Alignment
	// ============================================================
	always_comb begin
		padded = {{extract_pipe_pkg::SLOTS{extract_isa_pkg::NOP_INSN}}, line_i};
		// Parcel offset to bit offset
		shamt = extract_isa_pkg::SHAMT_W'(
			pc_i[extract_isa_pkg::OFS_MSB:extract_isa_pkg::OFS_LSB] * extract_isa_pkg::PARCEL_W);
		shifted = padded >> shamt;
		window = shifted[extract_pipe_pkg::WIN_W-1:0];
		for (int i = 0; i < extract_pipe_pkg::SLOTS; i++) begin
			slot_pc_o[i] = pc_i + extract_isa_pkg::pc_t'(i * extract_isa_pkg::INSN_BYTES);
			slot_insn_o[i] = window[i*extract_isa_pkg::INSN_W +: extract_isa_pkg::INSN_W];
		end
	end

	// ============================================================
	// Redundant group detection
	// ============================================================
	// Nothing to compare against until the first enabled edge
	always_ff @(posedge clk) begin
		if (rst_i) begin
			prev_vld <= 1'b0;
		end else if (en_i) begin
			prev_vld <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (en_i) begin
			prev_pc <= pc_i;
			prev_win <= window;
		end
	end

	// Same PC and same bytes means fetch repeated the group
	assign redundant_o = prev_vld && (prev_pc == pc_i) && (prev_win == window);

endmodule

`default_nettype wire

/* src/extract_pipe_pkg.sv */
`default_nettype none

package extract_pipe_pkg;

	// ============================================================
	// Group geometry
	// ============================================================
	localparam int SLOTS = 4;
	localparam int POS_W = $clog2(SLOTS);
	// Aligned window that holds one whole group
	localparam int WIN_W = SLOTS * extract_isa_pkg::INSN_W;
	// Sequential step from one group to the next
	localparam int GROUP_BYTES = SLOTS * extract_isa_pkg::INSN_BYTES;

	typedef logic [POS_W-1:0] pos_t;

	// Change-of-flow class of a slot
	typedef enum logic [2:0] {
		FLOW_NONE,
		FLOW_BSR,
		FLOW_BRA,
		FLOW_BCC,
		FLOW_JSR,
		FLOW_JMP
	} flow_e;

	typedef struct packed {
		extract_isa_pkg::insn_t insn;
		extract_isa_pkg::pc_t pc;
		logic pred_taken;
		logic valid;
		logic done;
		logic stomped;
	} slot_t;

	typedef struct packed {
		extract_isa_pkg::pc_t pc;
		logic flush;
		logic ssm;
	} group_hdr_t;

	typedef struct packed {
		group_hdr_t hdr;
		slot_t [SLOTS-1:0] slot;
	} group_t;

	// Fetch redirect from the first change-of-flow slot
	typedef struct packed {
		logic override;
		pos_t pos;
		extract_isa_pkg::pc_t target;
		logic is_call;
	} redirect_t;

	// Reasons a slot gets stomped, any bit set kills it
	typedef struct packed {
		logic ext;
		logic irq;
		logic redundant;
		logic miss;
		logic after_ovr;
		logic ssm;
		logic kind;
	} stomp_cause_t;

endpackage

`default_nettype wire

/* src/extract_isa_pkg.sv */
`default_nettype none

package extract_isa_pkg;

	// ============================================================
	// Widths and line geometry
	// ============================================================
	localparam int PC_W = 32;
	localparam int INSN_W = 48;
	localparam int INSN_BYTES = INSN_W / 8;
	localparam int LINE_W = 512;
	localparam int PARCEL_W = 16;
	// Fetch PC bits that hold the parcel offset within the line
	localparam int OFS_LSB = $clog2(PARCEL_W / 8);
	localparam int OFS_MSB = $clog2(LINE_W / 8) - 1;
	// Bit shift that aligns the line, at most one line minus a parcel
	localparam int SHAMT_W = $clog2(LINE_W);

	// Instruction field positions
	localparam int OPC_W = 7;
	localparam int DISP_LSB = 16;

	typedef logic [PC_W-1:0] pc_t;

	// Fetch restarts here, also the "no redirect" address
	localparam pc_t RST_PC = 32'hFFFC_0100;

	// Major opcodes, other codes are ordinary instructions
	typedef enum logic [OPC_W-1:0] {
		OP_NOP = 7'h0B,
		OP_ALU = 7'h04,
		OP_BSR = 7'h20,
		OP_BRA = 7'h21,
		OP_BCC = 7'h22,
		OP_JSR = 7'h24,
		OP_JMP = 7'h25
	} opcode_e;

	// Displacement or absolute target lives in the top 32 bits
	typedef struct packed {
		logic [PC_W-1:0] field;
		logic [DISP_LSB-OPC_W-1:0] rsvd;
		logic [OPC_W-1:0] opcode;
	} insn_t;

	// Filler past the end of the cache line
	localparam logic [INSN_W-1:0] NOP_INSN = {{(INSN_W - OPC_W){1'b0}}, OP_NOP};

endpackage

`default_nettype wire
